/* src/pdp_med_pkg.sv */
`default_nettype none

package pdp_med_pkg;

    // operator codes, telling which core operator produced a median word.
    localparam logic [1:0] OP_ZERO   = 2'd0;
    localparam logic [1:0] OP_PAIR   = 2'd1;
    localparam logic [1:0] OP_TRIPLE = 2'd2;
    localparam logic [1:0] OP_QUAD   = 2'd3;

    // kernel width codes as seen on reg2dp_kernel_width.
    localparam logic [2:0] KW_2X2 = 3'd1;
    localparam logic [2:0] KW_1X3 = 3'd2;

    // samples per window.
    localparam logic [2:0] WIN_LEN_2X2 = 3'd4;
    localparam logic [2:0] WIN_LEN_1X3 = 3'd3;

    // number of non-increasing triples of signed 3-bit values.
    localparam int LUT_CODES = 120;

    // the 22-bit median word and its views.
    // a single sample is carried sign-extended in raw, or as a bare low byte
    // once it has passed the zero operator.
    typedef union packed {
        logic [21:0] raw;
        struct packed {
            logic [1:0] tag;
            logic [3:0] pad;
            logic [7:0] min_val;
            logic [7:0] max_val;
        } pair;
        struct packed {
            logic [6:0] code;
            logic [4:0] min_lsb;
            logic [4:0] mid_lsb;
            logic [4:0] max_lsb;
        } triple;
        struct packed {
            logic [13:0] ext;
            logic [7:0]  med;
        } quad;
    } med_word_u;

endpackage

`default_nettype wire

/* src/pdp_med1d_lut.sv */
`timescale 1ns/10ps
`default_nettype none

module pdp_med1d_lut (
    // encoder side, three sorted MSB fields with hi >= mid >= lo.
    input  logic [2:0] msb_hi,
    input  logic [2:0] msb_mid,
    input  logic [2:0] msb_lo,
    output logic [6:0] code,
    // decoder side.
    input  logic [6:0] code_in,
    output logic [2:0] dec_hi,
    output logic [2:0] dec_mid,
    output logic [2:0] dec_lo
);

    // the code of a triple is its position when all non-increasing signed
    // triples are listed by ascending hi, then mid, then lo.
    // both directions walk the same list, so they always agree.
    always_comb begin : walk_triples
        int idx;
        int in_hi;
        int in_mid;
        int in_lo;

        code    = 7'd0;
        dec_hi  = 3'd0;
        dec_mid = 3'd0;
        dec_lo  = 3'd0;
        idx     = 0;
        in_hi   = int'($signed(msb_hi));
        in_mid  = int'($signed(msb_mid));
        in_lo   = int'($signed(msb_lo));

        for (int h = -4; h < 4; h++) begin
            for (int m = -4; m < 4; m++) begin
                for (int l = -4; l < 4; l++) begin
                    if (m <= h && l <= m) begin
                        if (h == in_hi && m == in_mid && l == in_lo) begin
                            code = 7'(idx);
                        end
                        // codes past the end of the table decode to zero.
                        if (code_in < pdp_med_pkg::LUT_CODES && 7'(idx) == code_in) begin
                            dec_hi  = 3'(h);
                            dec_mid = 3'(m);
                            dec_lo  = 3'(l);
                        end
                        idx++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/pdp_med1d_core.sv */
`timescale 1ns/10ps
`default_nettype none

module pdp_med1d_core (
    input  logic [2:0]              reg2dp_kernel_width,
    input  pdp_med_pkg::med_word_u  word_a,
    input  pdp_med_pkg::med_word_u  word_b,
    output pdp_med_pkg::med_word_u  med_word,
    output logic [1:0]              med_op
);

    pdp_med_pkg::med_word_u a_n;
    pdp_med_pkg::med_word_u b_n;
    pdp_med_pkg::med_word_u survivor;
    pdp_med_pkg::med_word_u zero_res;
    pdp_med_pkg::med_word_u pair_res;
    pdp_med_pkg::med_word_u trip_res;
    pdp_med_pkg::med_word_u quad_res;
    pdp_med_pkg::med_word_u pair_in;

    logic       zero_a;
    logic       zero_b;
    logic       pair_a;
    logic       pair_b;
    logic       surv_pair;
    logic       is_2x2;
    logic [7:0] single;
    logic       gt_max;
    logic       gt_min;
    logic [7:0] t_hi;
    logic [7:0] t_mid;
    logic [7:0] t_lo;
    logic [7:0] max_of_mins;
    logic [7:0] min_of_maxes;
    logic [7:0] quad_byte;
    logic [6:0] lut_code;

    // a negative single arrives sign-extended; only its low byte is kept.
    assign a_n.raw = (word_a.raw[21:8] == '1) ? {14'd0, word_a.raw[7:0]} : word_a.raw;
    assign b_n.raw = (word_b.raw[21:8] == '1) ? {14'd0, word_b.raw[7:0]} : word_b.raw;

    assign zero_a = (a_n.raw == '0);
    assign zero_b = (b_n.raw == '0);
    assign pair_a = (a_n.pair.tag == 2'b11);
    assign pair_b = (b_n.pair.tag == 2'b11);
    assign is_2x2 = (reg2dp_kernel_width == pdp_med_pkg::KW_2X2);

    // zero operator. padding drops out; a pair already built survives whole,
    // so a late zero sample does not break a 1x3 window.
    assign survivor  = zero_a ? b_n : a_n;
    assign surv_pair = (survivor.pair.tag == 2'b11);
    assign zero_res.raw = surv_pair ? survivor.raw : {14'd0, survivor.raw[7:0]};

    // pair operator: two singles sorted, max in the low byte.
    always_comb begin
        pair_res.pair.tag = 2'b11;
        pair_res.pair.pad = 4'd0;
        if ($signed(a_n.raw[7:0]) > $signed(b_n.raw[7:0])) begin
            pair_res.pair.max_val = a_n.raw[7:0];
            pair_res.pair.min_val = b_n.raw[7:0];
        end else begin
            pair_res.pair.max_val = b_n.raw[7:0];
            pair_res.pair.min_val = a_n.raw[7:0];
        end
    end

    // triple operator: insert the single into the sorted pair.
    assign pair_in = pair_a ? a_n : b_n;
    assign single  = pair_a ? b_n.raw[7:0] : a_n.raw[7:0];
    assign gt_max  = ($signed(pair_in.pair.max_val) > $signed(single));
    assign gt_min  = ($signed(pair_in.pair.min_val) > $signed(single));

    assign t_hi  = gt_max ? pair_in.pair.max_val : single;
    assign t_mid = !gt_max ? pair_in.pair.max_val : (gt_min ? pair_in.pair.min_val : single);
    assign t_lo  = gt_min ? single : pair_in.pair.min_val;

    // the three MSB fields are squeezed into one table code.
    pdp_med1d_lut i_lut (
        .msb_hi  (t_hi[7:5]),
        .msb_mid (t_mid[7:5]),
        .msb_lo  (t_lo[7:5]),
        .code    (lut_code),
        .code_in (7'd0),
        .dec_hi  (),
        .dec_mid (),
        .dec_lo  ()
    );

    assign trip_res.triple.code    = lut_code;
    assign trip_res.triple.min_lsb = t_lo[4:0];
    assign trip_res.triple.mid_lsb = t_mid[4:0];
    assign trip_res.triple.max_lsb = t_hi[4:0];

    // quad operator: second smallest of two sorted pairs.
    assign max_of_mins = ($signed(a_n.pair.min_val) > $signed(b_n.pair.min_val)) ?
                         a_n.pair.min_val : b_n.pair.min_val;
    assign min_of_maxes = ($signed(a_n.pair.max_val) < $signed(b_n.pair.max_val)) ?
                          a_n.pair.max_val : b_n.pair.max_val;
    assign quad_byte = ($signed(max_of_mins) < $signed(min_of_maxes)) ?
                       max_of_mins : min_of_maxes;
    assign quad_res.quad.ext = {14{quad_byte[7]}};
    assign quad_res.quad.med = quad_byte;

    always_comb begin
        if (zero_a || zero_b) begin
            med_op = surv_pair ? pdp_med_pkg::OP_PAIR : pdp_med_pkg::OP_ZERO;
        end else if ((pair_a || pair_b) && !is_2x2) begin
            med_op = pdp_med_pkg::OP_TRIPLE;
        end else if (pair_a && pair_b && is_2x2) begin
            med_op = pdp_med_pkg::OP_QUAD;
        end else begin
            med_op = pdp_med_pkg::OP_PAIR;
        end
    end

    always_comb begin
        if (zero_a || zero_b) begin
            med_word = zero_res;
        end else begin
            case (med_op)
                pdp_med_pkg::OP_TRIPLE: med_word = trip_res;
                pdp_med_pkg::OP_QUAD:   med_word = quad_res;
                default:                med_word = pair_res;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/pdp_med1d_fold.sv */
`timescale 1ns/10ps
`default_nettype none

module pdp_med1d_fold (
    input  logic                    nvdla_core_clk,
    input  logic                    rst_n,
    input  logic [2:0]              reg2dp_kernel_width,
    input  logic                    sample_valid,
    input  logic [7:0]              sample,
    output logic                    final_valid,
    output pdp_med_pkg::med_word_u  final_word,
    output logic [1:0]              final_op
);

    pdp_med_pkg::med_word_u acc;
    pdp_med_pkg::med_word_u hold;
    pdp_med_pkg::med_word_u acc_a;
    pdp_med_pkg::med_word_u acc_b;
    pdp_med_pkg::med_word_u core_word;

    logic [1:0] core_op;
    logic [2:0] core_kw;
    logic [2:0] win_cnt;
    logic       combine;
    logic       is_2x2;
    logic       last_1x3;
    logic       half_2x2;
    logic       last_2x2;

    assign is_2x2 = (reg2dp_kernel_width == pdp_med_pkg::KW_2X2);

    // the combine cycle merges the held row pair with the second row pair.
    assign acc_a.raw = combine ? hold.raw : acc.raw;
    assign acc_b.raw = combine ? acc.raw : {{14{sample[7]}}, sample};
    assign core_kw   = combine ? pdp_med_pkg::KW_2X2 : reg2dp_kernel_width;

    assign last_1x3 = sample_valid && !is_2x2 &&
                      (win_cnt == pdp_med_pkg::WIN_LEN_1X3 - 3'd1);
    assign half_2x2 = sample_valid && is_2x2 &&
                      (win_cnt == (pdp_med_pkg::WIN_LEN_2X2 >> 1) - 3'd1);
    assign last_2x2 = sample_valid && is_2x2 &&
                      (win_cnt == pdp_med_pkg::WIN_LEN_2X2 - 3'd1);

    pdp_med1d_core i_core (
        .reg2dp_kernel_width (core_kw),
        .word_a              (acc_a),
        .word_b              (acc_b),
        .med_word            (core_word),
        .med_op              (core_op)
    );

    always_ff @(posedge nvdla_core_clk) begin
        if (!rst_n) begin
            win_cnt     <= 3'd0;
            acc         <= '0;
            hold        <= '0;
            combine     <= 1'b0;
            final_valid <= 1'b0;
        end else begin
            final_valid <= 1'b0;
            if (combine) begin
                combine     <= 1'b0;
                acc         <= '0;
                hold        <= '0;
                final_valid <= 1'b1;
            end else if (last_1x3) begin
                win_cnt     <= 3'd0;
                acc         <= '0;
                final_valid <= 1'b1;
            end else if (last_2x2) begin
                win_cnt <= 3'd0;
                acc     <= core_word;
                combine <= 1'b1;
            end else if (half_2x2) begin
                // first row is done, park it and start the second row empty.
                win_cnt <= win_cnt + 3'd1;
                hold    <= core_word;
                acc     <= '0;
            end else if (sample_valid) begin
                win_cnt <= win_cnt + 3'd1;
                acc     <= core_word;
            end
        end
    end

    always_ff @(posedge nvdla_core_clk) begin
        if (combine || last_1x3) begin
            final_word <= core_word;
            final_op   <= core_op;
        end
    end

endmodule

`default_nettype wire

/* src/pdp_med1d_extract.sv */
`timescale 1ns/10ps
`default_nettype none

module pdp_med1d_extract (
    input  logic                    final_valid,
    input  pdp_med_pkg::med_word_u  final_word,
    input  logic [1:0]              final_op,
    output logic                    med_valid,
    output logic [7:0]              med_out
);

    logic [2:0] mid_msb;

    // only the decoder half of the table is needed here.
    pdp_med1d_lut i_lut (
        .msb_hi  (3'd0),
        .msb_mid (3'd0),
        .msb_lo  (3'd0),
        .code    (),
        .code_in (final_word.triple.code),
        .dec_hi  (),
        .dec_mid (mid_msb),
        .dec_lo  ()
    );

    assign med_valid = final_valid;

    always_comb begin
        case (final_op)
            pdp_med_pkg::OP_TRIPLE: med_out = {mid_msb, final_word.triple.mid_lsb};
            // with two live samples the lower one is the median.
            pdp_med_pkg::OP_PAIR:   med_out = final_word.pair.min_val;
            // zero and quad words both keep the median in the low byte.
            default:                med_out = final_word.raw[7:0];
        endcase
    end

endmodule

`default_nettype wire

/* src/pdp_med1d_top.sv */
`timescale 1ns/10ps
`default_nettype none

module pdp_med1d_top (
    input  logic       nvdla_core_clk,
    input  logic       rst_n,
    input  logic [2:0] reg2dp_kernel_width,
    input  logic       sample_valid,
    input  logic [7:0] sample,
    output logic       med_valid,
    output logic [7:0] med_out
);

    pdp_med_pkg::med_word_u final_word;

    logic       final_valid;
    logic [1:0] final_op;

    // samples are folded into one median word per window.
    pdp_med1d_fold i_fold (
        .nvdla_core_clk      (nvdla_core_clk),
        .rst_n               (rst_n),
        .reg2dp_kernel_width (reg2dp_kernel_width),
        .sample_valid        (sample_valid),
        .sample              (sample),
        .final_valid         (final_valid),
        .final_word          (final_word),
        .final_op            (final_op)
    );

    // the final word is turned back into a plain signed byte.
    pdp_med1d_extract i_extract (
        .final_valid (final_valid),
        .final_word  (final_word),
        .final_op    (final_op),
        .med_valid   (med_valid),
        .med_out     (med_out)
    );

endmodule

`default_nettype wire

/* dv/pdp_med1d_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module pdp_med1d_assertions (
    input logic nvdla_core_clk,
    input logic rst_n,
    input logic sample_valid,
    input logic combine,
    input logic final_valid
);

    // a reset cycle leaves no result pending.
    final_low_after_reset: assert property (
        @(posedge nvdla_core_clk) !rst_n |=> !final_valid
    ) else $error("final_valid high in the cycle after reset");

    // the fold has no back-pressure, so the combine cycle must be quiet.
    no_strobe_in_combine: assert property (
        @(posedge nvdla_core_clk) disable iff (!rst_n) combine |-> !sample_valid
    ) else $error("sample strobe arrived during the 2x2 combine cycle");

    // a result trails the strobe that ended its window by one or two cycles.
    result_follows_strobe: assert property (
        @(posedge nvdla_core_clk) disable iff (!rst_n)
        final_valid |-> ($past(sample_valid, 1) || $past(sample_valid, 2))
    ) else $error("final_valid with no strobe one or two cycles before");

endmodule

bind pdp_med1d_fold pdp_med1d_assertions i_fold_assertions (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .sample_valid   (sample_valid),
    .combine        (combine),
    .final_valid    (final_valid)
);

`default_nettype wire

/* dv/pdp_med1d_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module pdp_med1d_checker (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       med_valid,
    input  logic [7:0] med_out,
    input  logic       exp_push,
    input  logic [7:0] exp_value,
    input  logic [1:0] exp_latency,
    output int         check_count,
    output int         error_count,
    output int         pending
);

    logic [7:0] exp_q [$];
    int         due_q [$];
    int         cycle;
    logic [7:0] want;
    int         due;

    // an expected entry arrives on the edge that takes the window's last sample.
    always @(posedge clk) begin
        if (!rst_n) begin
            cycle       = 0;
            check_count = 0;
            error_count = 0;
            pending     = 0;
            exp_q.delete();
            due_q.delete();
        end else begin
            cycle = cycle + 1;
            if (med_valid) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("med_valid pulsed at cycle %0d with no window waiting", cycle);
                end else begin
                    want = exp_q.pop_front();
                    due  = due_q.pop_front();
                    check_count++;
                    if (med_out !== want) begin
                        error_count++;
                        $display("CHECK FAILED med_out: got 0x%02h, expected 0x%02h",
                                 med_out, want);
                    end
                    if (cycle != due) begin
                        error_count++;
                        $display("med_valid came at cycle %0d but was due at cycle %0d",
                                 cycle, due);
                    end
                end
            end
            // a result past its due cycle is missing and is dropped once reported.
            if (due_q.size() != 0 && due_q[0] < cycle) begin
                error_count++;
                $display("no med_valid for the window whose result was due at cycle %0d",
                         due_q[0]);
                want = exp_q.pop_front();
                due  = due_q.pop_front();
            end
            if (exp_push) begin
                exp_q.push_back(exp_value);
                due_q.push_back(cycle + int'(exp_latency));
            end
            pending = exp_q.size();
        end
    end

endmodule

`default_nettype wire

/* dv/pdp_med1d_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module pdp_med1d_tb;

    localparam int NUM_ROWS    = 18;
    localparam int NUM_RANDOM  = 150;
    localparam int DRAIN_LIMIT = 50;

    // each row holds kernel width, four samples (first sample in the top byte) and the median.
    localparam logic [42:0] VECTORS [0:NUM_ROWS-1] = '{
        {3'd2, 32'h05030900, 8'h05},
        {3'd2, 32'h807F0100, 8'h01},
        {3'd2, 32'h7F80FF00, 8'hFF},
        {3'd2, 32'hF010E000, 8'hF0},
        {3'd2, 32'h22221100, 8'h22},
        {3'd2, 32'h81C03F00, 8'hC0},
        {3'd2, 32'h0040C000, 8'hC0},
        {3'd2, 32'h30002000, 8'h20},
        {3'd2, 32'h50600000, 8'h50},
        {3'd2, 32'h00009C00, 8'h9C},
        {3'd2, 32'h000A0000, 8'h0A},
        {3'd2, 32'h00000000, 8'h00},
        {3'd1, 32'h10402030, 8'h20},
        {3'd1, 32'h807FFF01, 8'hFF},
        {3'd1, 32'h05050505, 8'h05},
        {3'd1, 32'hC090A0B0, 8'hA0},
        {3'd0, 32'h09010500, 8'h05},
        {3'd5, 32'h60A00000, 8'hA0}
    };

    logic        nvdla_core_clk;
    logic        rst_n;
    logic [2:0]  reg2dp_kernel_width;
    logic        sample_valid;
    logic [7:0]  sample;
    logic        med_valid;
    logic [7:0]  med_out;
    logic        exp_push;
    logic [7:0]  exp_value;
    logic [1:0]  exp_latency;
    int          check_count;
    int          error_count;
    int          pending;
    int          tb_errors;
    int          windows;

    initial begin
        nvdla_core_clk = 1'b0;
        forever #4 nvdla_core_clk = ~nvdla_core_clk;
    end

    pdp_med1d_top i_dut (
        .nvdla_core_clk      (nvdla_core_clk),
        .rst_n               (rst_n),
        .reg2dp_kernel_width (reg2dp_kernel_width),
        .sample_valid        (sample_valid),
        .sample              (sample),
        .med_valid           (med_valid),
        .med_out             (med_out)
    );

    pdp_med1d_checker i_checker (
        .clk         (nvdla_core_clk),
        .rst_n       (rst_n),
        .med_valid   (med_valid),
        .med_out     (med_out),
        .exp_push    (exp_push),
        .exp_value   (exp_value),
        .exp_latency (exp_latency),
        .check_count (check_count),
        .error_count (error_count),
        .pending     (pending)
    );

    // the reference median comes from a plain sort of the live samples.
    function automatic logic [7:0] window_median(input logic [2:0] mode,
                                                 input logic [31:0] samples);
        int vals [4];
        int n;
        int len;
        int tmp;
        n   = 0;
        len = (mode == pdp_med_pkg::KW_2X2) ? 4 : 3;
        for (int i = 0; i < len; i++) begin
            // padding takes no part in a 1x3 median.
            if (samples[31 - 8*i -: 8] != 8'd0 || len == 4) begin
                vals[n] = int'($signed(samples[31 - 8*i -: 8]));
                n++;
            end
        end
        for (int i = 1; i < n; i++) begin
            for (int k = i; k > 0 && vals[k-1] > vals[k]; k--) begin
                tmp       = vals[k];
                vals[k]   = vals[k-1];
                vals[k-1] = tmp;
            end
        end
        if (n == 0) begin
            return 8'd0;
        end
        // an even count takes the lower of the two middle values.
        return 8'(vals[(n - 1) / 2]);
    endfunction

    task automatic run_window(input logic [2:0] mode, input logic [31:0] samples,
                              input logic [7:0] expected, input int idle);
        int len;
        int quiet;
        len   = (mode == pdp_med_pkg::KW_2X2) ? 4 : 3;
        quiet = idle;
        for (int i = 0; i < len; i++) begin
            @(posedge nvdla_core_clk);
            reg2dp_kernel_width <= mode;
            sample_valid        <= 1'b1;
            sample              <= samples[31 - 8*i -: 8];
            exp_push            <= (i == len - 1);
            exp_value           <= expected;
            exp_latency         <= (len == 4) ? 2'd2 : 2'd1;
        end
        // a 2x2 window needs one quiet cycle for its combine step.
        if (len == 4 && quiet == 0) begin
            quiet = 1;
        end
        for (int i = 0; i < quiet; i++) begin
            @(posedge nvdla_core_clk);
            sample_valid <= 1'b0;
            exp_push     <= 1'b0;
        end
        windows++;
    endtask

    initial begin
        logic [7:0]  trio [3];
        logic [7:0]  tmp_byte;
        logic [31:0] samples;
        logic [2:0]  mode;
        int          j;

        rst_n               = 1'b0;
        reg2dp_kernel_width = pdp_med_pkg::KW_1X3;
        sample_valid        = 1'b0;
        sample              = 8'd0;
        exp_push            = 1'b0;
        exp_value           = 8'd0;
        exp_latency         = 2'd0;
        tb_errors           = 0;
        windows             = 0;
        void'($urandom(32'hb28f));
        repeat (10) @(posedge nvdla_core_clk);
        rst_n <= 1'b1;

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_window(VECTORS[r][42:40], VECTORS[r][39:8], VECTORS[r][7:0], 0);
        end

        // each sorted triple of MSB fields is sent once with random LSBs and order.
        for (int h = -4; h < 4; h++) begin
            for (int m = -4; m <= h; m++) begin
                for (int l = -4; l <= m; l++) begin
                    trio[0] = {3'(h), 5'($urandom)};
                    trio[1] = {3'(m), 5'($urandom)};
                    trio[2] = {3'(l), 5'($urandom)};
                    for (int i = 0; i < 3; i++) begin
                        if (trio[i] == 8'd0) begin
                            trio[i] = 8'h01;
                        end
                    end
                    for (int i = 2; i > 0; i--) begin
                        j        = int'($urandom % (i + 1));
                        tmp_byte = trio[i];
                        trio[i]  = trio[j];
                        trio[j]  = tmp_byte;
                    end
                    samples = {trio[0], trio[1], trio[2], 8'h00};
                    run_window(pdp_med_pkg::KW_1X3, samples,
                               window_median(pdp_med_pkg::KW_1X3, samples), int'($urandom % 2));
                end
            end
        end

        for (int w = 0; w < NUM_RANDOM; w++) begin
            mode    = ($urandom % 3 == 0) ? pdp_med_pkg::KW_2X2 : pdp_med_pkg::KW_1X3;
            samples = $urandom;
            for (int i = 0; i < 4; i++) begin
                if (mode == pdp_med_pkg::KW_2X2 && samples[8*i +: 8] == 8'd0) begin
                    samples[8*i +: 8] = 8'h01;
                end else if (mode != pdp_med_pkg::KW_2X2 && $urandom % 6 == 0) begin
                    samples[8*i +: 8] = 8'h00;
                end
            end
            run_window(mode, samples, window_median(mode, samples), int'($urandom % 3));
        end

        @(posedge nvdla_core_clk);
        sample_valid <= 1'b0;
        exp_push     <= 1'b0;
        @(negedge nvdla_core_clk);
        for (int t = 0; t < DRAIN_LIMIT && pending != 0; t++) begin
            @(negedge nvdla_core_clk);
        end
        if (pending != 0) begin
            tb_errors++;
            $display("timed out with %0d windows still waiting for a result", pending);
        end

        $display("windows %0d, results checked %0d, errors %0d",
                 windows, check_count, error_count + tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
src/pdp_med_pkg.sv
src/pdp_med1d_lut.sv
src/pdp_med1d_core.sv
src/pdp_med1d_fold.sv
src/pdp_med1d_extract.sv
src/pdp_med1d_top.sv
dv/pdp_med1d_assertions.sv
dv/pdp_med1d_checker.sv
dv/pdp_med1d_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := pdp_med1d_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
PASS_MSG  := Simulation completed successfully
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source file or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(SIM_LOG) 2>&1
	@cat $(SIM_LOG)
	@grep -q "^$(PASS_MSG)$$" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
